// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tbCache
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: all.f
+incdir+.
cacheCfgPkg.sv
cacheIfPkg.sv
cacheCtrl.sv
tagStore.sv
dataStore.sv
refillBuffer.sv
icacheTop.sv
tbCache.sv

// File: cacheCfgPkg.sv
`default_nettype none

package cacheCfgPkg;

  // address and data geometry
  localparam int AddrWidth = 32;
  localparam int XLen = 64;

  // two ways of 64 sets, 32-byte lines
  localparam int NumSets = 64;
  localparam int IndexWidth = 6;
  localparam int OffsetWidth = 5;
  localparam int TagWidth = 21;

  // one line is refilled as four 64-bit beats
  localparam int BeatsPerLine = 4;
  localparam int LineWidth = 256;

  // fields of a core address, msb first
  typedef struct packed {
    logic [TagWidth-1:0]                           tag;
    logic [IndexWidth-1:0]                         index;
    logic [$clog2(BeatsPerLine)-1:0]               wordSel;
    logic [OffsetWidth-$clog2(BeatsPerLine)-1:0]   byteOff;
  } cacheAddr_t;

  // controller states
  typedef enum logic [2:0] {
    Idle    = 3'd0,
    Compare = 3'd1,
    MissReq = 3'd2,
    Refill  = 3'd3,
    Install = 3'd4,
    Respond = 3'd5
  } ctrlState_e;

endpackage

`default_nettype wire

// File: cacheCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module cacheCtrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cacheIfPkg::coreReq_t     coreReq_i,
  output logic                     addrOk_o,
  output logic                     dataOk_o,
  output logic                     lookupEn_o,
  output cacheCfgPkg::cacheAddr_t  reqAddr_o,
  input  logic                     hit_i,
  input  logic                     hitWay_i,
  input  logic                     victimWay_i,
  output cacheIfPkg::memReq_t      memReq_o,
  input  logic                     rdReady_i,
  input  logic                     lineFull_i,
  output logic                     install_o,
  output logic                     installWay_o,
  output logic                     respFromRefill_o
);

  cacheCfgPkg::ctrlState_e  state;
  cacheCfgPkg::ctrlState_e  stateNext;
  cacheCfgPkg::cacheAddr_t  reqQ;
  logic                     wayQ;
  logic                     accept;

  // a new request goes in when idle or right behind a hit
  assign accept = coreReq_i.valid &&
                  ((state == cacheCfgPkg::Idle) ||
                   ((state == cacheCfgPkg::Compare) && hit_i));

  always_comb begin
    stateNext = state;
    case (state)
      cacheCfgPkg::Idle: begin
        if (coreReq_i.valid) begin
          stateNext = cacheCfgPkg::Compare;
        end
      end
      cacheCfgPkg::Compare: begin
        if (!hit_i) begin
          stateNext = cacheCfgPkg::MissReq;
        end else if (!coreReq_i.valid) begin
          stateNext = cacheCfgPkg::Idle;
        end
      end
      cacheCfgPkg::MissReq: begin
        if (rdReady_i) begin
          stateNext = cacheCfgPkg::Refill;
        end
      end
      cacheCfgPkg::Refill: begin
        if (lineFull_i) begin
          stateNext = cacheCfgPkg::Install;
        end
      end
      cacheCfgPkg::Install: begin
        stateNext = cacheCfgPkg::Respond;
      end
      default: begin
        stateNext = cacheCfgPkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cacheCfgPkg::Idle;
    end else begin
      state <= stateNext;
    end
  end

  // request address, held across the whole miss
  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= cacheCfgPkg::cacheAddr_t'(coreReq_i.addr);
    end
  end

  // way of the last lookup, the victim once a miss is seen
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wayQ <= 1'b0;
    end else if (state == cacheCfgPkg::Compare) begin
      wayQ <= hit_i ? hitWay_i : victimWay_i;
    end
  end

  assign addrOk_o   = accept;
  assign lookupEn_o = accept;
  // stores index with the live address on lookup, latched one otherwise
  assign reqAddr_o  = accept ? cacheCfgPkg::cacheAddr_t'(coreReq_i.addr) : reqQ;

  assign dataOk_o = ((state == cacheCfgPkg::Compare) && hit_i) ||
                    (state == cacheCfgPkg::Respond);
  assign respFromRefill_o = (state == cacheCfgPkg::Respond);

  assign memReq_o.rdValid = (state == cacheCfgPkg::MissReq);
  assign memReq_o.addr    = {reqQ.tag, reqQ.index, {cacheCfgPkg::OffsetWidth{1'b0}}};

  assign install_o    = (state == cacheCfgPkg::Install);
  assign installWay_o = wayQ;

endmodule

`default_nettype wire

// File: cacheIfPkg.sv
`default_nettype none

package cacheIfPkg;

  // core side request, held by the core until addrOk
  typedef struct packed {
    logic                                valid;
    logic [cacheCfgPkg::AddrWidth-1:0]   addr;
  } coreReq_t;

  // core side response, dataOk is a single-cycle pulse
  typedef struct packed {
    logic                                addrOk;
    logic                                dataOk;
    logic [cacheCfgPkg::XLen-1:0]        rdData;
  } coreResp_t;

  // burst read request, line aligned
  typedef struct packed {
    logic                                rdValid;
    logic [cacheCfgPkg::AddrWidth-1:0]   addr;
  } memReq_t;

  // burst read response
  typedef struct packed {
    logic                                rdReady;
    logic                                beatValid;
    logic                                beatLast;
    logic [cacheCfgPkg::XLen-1:0]        beatData;
  } memResp_t;

endpackage

`default_nettype wire

// File: dataStore.sv
`timescale 1ns/100ps
`default_nettype none

module dataStore (
  input  logic                              clk,
  input  logic                              lookupEn_i,
  input  cacheCfgPkg::cacheAddr_t           lookupAddr_i,
  input  logic                              hitWay_i,
  input  logic                              install_i,
  input  logic                              installWay_i,
  input  logic [cacheCfgPkg::LineWidth-1:0] installLine_i,
  output logic [cacheCfgPkg::XLen-1:0]      rdWord_o
);

  logic [cacheCfgPkg::LineWidth-1:0]   way0Arr [cacheCfgPkg::NumSets];
  logic [cacheCfgPkg::LineWidth-1:0]   way1Arr [cacheCfgPkg::NumSets];
  logic [cacheCfgPkg::XLen-1:0]        word0Q;
  logic [cacheCfgPkg::XLen-1:0]        word1Q;
  logic [cacheCfgPkg::IndexWidth-1:0]  idxQ;

  // both ways read on lookup, word picked before the register
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      word0Q <= way0Arr[lookupAddr_i.index][lookupAddr_i.wordSel*cacheCfgPkg::XLen +:
                                            cacheCfgPkg::XLen];
      word1Q <= way1Arr[lookupAddr_i.index][lookupAddr_i.wordSel*cacheCfgPkg::XLen +:
                                            cacheCfgPkg::XLen];
      idxQ   <= lookupAddr_i.index;
    end
  end

  // line install into the victim way of the missed set
  always_ff @(posedge clk) begin
    if (install_i && !installWay_i) begin
      way0Arr[idxQ] <= installLine_i;
    end
    if (install_i && installWay_i) begin
      way1Arr[idxQ] <= installLine_i;
    end
  end

  assign rdWord_o = hitWay_i ? word1Q : word0Q;

endmodule

`default_nettype wire

// File: icacheTop.sv
`timescale 1ns/100ps
`default_nettype none

module icacheTop (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cacheIfPkg::coreReq_t  coreReq_i,
  output cacheIfPkg::coreResp_t coreResp_o,
  output cacheIfPkg::memReq_t   memReq_o,
  input  cacheIfPkg::memResp_t  memResp_i
);

  cacheCfgPkg::cacheAddr_t            reqAddr;
  logic                               lookupEn;
  logic                               hit;
  logic                               hitWay;
  logic                               victimWay;
  logic                               lineFull;
  logic                               install;
  logic                               installWay;
  logic                               respFromRefill;
  logic [cacheCfgPkg::LineWidth-1:0]  refillLine;
  logic [cacheCfgPkg::XLen-1:0]       storeWord;
  logic [cacheCfgPkg::XLen-1:0]       critWord;

  cacheCtrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .coreReq_i        (coreReq_i),
    .addrOk_o         (coreResp_o.addrOk),
    .dataOk_o         (coreResp_o.dataOk),
    .lookupEn_o       (lookupEn),
    .reqAddr_o        (reqAddr),
    .hit_i            (hit),
    .hitWay_i         (hitWay),
    .victimWay_i      (victimWay),
    .memReq_o         (memReq_o),
    .rdReady_i        (memResp_i.rdReady),
    .lineFull_i       (lineFull),
    .install_o        (install),
    .installWay_o     (installWay),
    .respFromRefill_o (respFromRefill)
  );

  tagStore u_tags (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookupEn_i   (lookupEn),
    .lookupAddr_i (reqAddr),
    .install_i    (install),
    .installWay_i (installWay),
    .hit_o        (hit),
    .hitWay_o     (hitWay),
    .victimWay_o  (victimWay)
  );

  dataStore u_data (
    .clk           (clk),
    .lookupEn_i    (lookupEn),
    .lookupAddr_i  (reqAddr),
    .hitWay_i      (hitWay),
    .install_i     (install),
    .installWay_i  (installWay),
    .installLine_i (refillLine),
    .rdWord_o      (storeWord)
  );

  refillBuffer u_refill (
    .clk        (clk),
    .rst_n      (rst_n),
    .memResp_i  (memResp_i),
    .wordSel_i  (reqAddr.wordSel),
    .lineFull_o (lineFull),
    .line_o     (refillLine),
    .critWord_o (critWord)
  );

  // miss responses come straight from the refill line
  assign coreResp_o.rdData = respFromRefill ? critWord : storeWord;

endmodule

`default_nettype wire

// File: refillBuffer.sv
`timescale 1ns/100ps
`default_nettype none

module refillBuffer (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  cacheIfPkg::memResp_t                     memResp_i,
  input  logic [$clog2(cacheCfgPkg::BeatsPerLine)-1:0] wordSel_i,
  output logic                                     lineFull_o,
  output logic [cacheCfgPkg::LineWidth-1:0]        line_o,
  output logic [cacheCfgPkg::XLen-1:0]             critWord_o
);

  logic [$clog2(cacheCfgPkg::BeatsPerLine)-1:0]  beatCnt;
  logic [cacheCfgPkg::LineWidth-1:0]             lineQ;

  // beat counter, back to zero after the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt    <= '0;
      lineFull_o <= 1'b0;
    end else begin
      lineFull_o <= memResp_i.beatValid && memResp_i.beatLast;
      if (memResp_i.beatValid) begin
        beatCnt <= memResp_i.beatLast ? '0 : beatCnt + 1'b1;
      end
    end
  end

  // lowest address arrives first
  always_ff @(posedge clk) begin
    if (memResp_i.beatValid) begin
      lineQ[beatCnt*cacheCfgPkg::XLen +: cacheCfgPkg::XLen] <= memResp_i.beatData;
    end
  end

  assign line_o     = lineQ;
  assign critWord_o = lineQ[wordSel_i*cacheCfgPkg::XLen +: cacheCfgPkg::XLen];

endmodule

`default_nettype wire

// File: tagStore.sv
`timescale 1ns/100ps
`default_nettype none

module tagStore (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     lookupEn_i,
  input  cacheCfgPkg::cacheAddr_t  lookupAddr_i,
  input  logic                     install_i,
  input  logic                     installWay_i,
  output logic                     hit_o,
  output logic                     hitWay_o,
  output logic                     victimWay_o
);

  logic [cacheCfgPkg::TagWidth-1:0]    tagArr [2][cacheCfgPkg::NumSets];
  logic [cacheCfgPkg::NumSets-1:0]     validArr [2];
  // per set, the least recently used way
  logic [cacheCfgPkg::NumSets-1:0]     lruArr;

  logic [cacheCfgPkg::TagWidth-1:0]    tagQ [2];
  logic [1:0]                          validQ;
  logic [cacheCfgPkg::TagWidth-1:0]    reqTagQ;
  logic [cacheCfgPkg::IndexWidth-1:0]  reqIdxQ;
  logic                                cmpValid;
  logic [1:0]                          wayHit;

  // set contents captured on lookup
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagQ[0] <= tagArr[0][lookupAddr_i.index];
      tagQ[1] <= tagArr[1][lookupAddr_i.index];
      reqTagQ <= lookupAddr_i.tag;
      reqIdxQ <= lookupAddr_i.index;
    end
    if (install_i) begin
      tagArr[installWay_i][reqIdxQ] <= reqTagQ;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr[0] <= '0;
      validArr[1] <= '0;
      validQ      <= 2'b00;
      lruArr      <= '0;
      cmpValid    <= 1'b0;
    end else begin
      cmpValid <= lookupEn_i;
      if (lookupEn_i) begin
        validQ <= {validArr[1][lookupAddr_i.index], validArr[0][lookupAddr_i.index]};
      end
      if (install_i) begin
        validArr[installWay_i][reqIdxQ] <= 1'b1;
        lruArr[reqIdxQ] <= ~installWay_i;
      end else if (cmpValid && hit_o) begin
        lruArr[reqIdxQ] <= ~hitWay_o;
      end
    end
  end

  assign wayHit[0] = validQ[0] && (tagQ[0] == reqTagQ);
  assign wayHit[1] = validQ[1] && (tagQ[1] == reqTagQ);

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // empty way first, way 0 before way 1, then lru
  always_comb begin
    if (!validQ[0]) begin
      victimWay_o = 1'b0;
    end else if (!validQ[1]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lruArr[reqIdxQ];
    end
  end

endmodule

`default_nettype wire

// File: tbTasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// reference model of tags, valid bits and lru per set
logic [20:0]  mTag[2][64];
logic         mValid[2][64];
logic         mLru[64];
int           expMemReqs;

task automatic reportMismatch(input string msg);
  $display("TB FAILED");
  $fatal(1, "mismatch at %0t: %s", $time, msg);
endtask

task automatic reportError(input string msg);
  $display("TB FAILED");
  $fatal(1, "error at %0t: %s", $time, msg);
endtask

function automatic logic [31:0] makeAddr(input int tag, input int idx, input int ws,
                                         input int off);
  return {21'(tag), 6'(idx), 2'(ws), 3'(off)};
endfunction

// memory content: the word address twice, scrambled
function automatic logic [63:0] memWord(input logic [31:0] addr);
  logic [31:0] w;
  w = {addr[31:3], 3'b000};
  return {w, w} ^ 64'h5a5a_c3c3_0ff0_a55a;
endfunction

task automatic resetModel();
  for (int s = 0; s < 64; s++) begin
    mValid[0][s] = 1'b0;
    mValid[1][s] = 1'b0;
    mLru[s]      = 1'b0;
  end
  expMemReqs = 0;
endtask

// predicts hit or miss and updates the model like the cache would
function automatic logic predictAccess(input logic [31:0] addr);
  logic [20:0] tag;
  int          idx;
  logic        way;
  tag = addr[31:11];
  idx = int'(addr[10:5]);
  for (int w = 0; w < 2; w++) begin
    if (mValid[w][idx] && mTag[w][idx] == tag) begin
      mLru[idx] = ~w[0];
      return 1'b1;
    end
  end
  if (!mValid[0][idx]) begin
    way = 1'b0;
  end else if (!mValid[1][idx]) begin
    way = 1'b1;
  end else begin
    way = mLru[idx];
  end
  mTag[way][idx]   = tag;
  mValid[way][idx] = 1'b1;
  mLru[idx]        = ~way;
  expMemReqs++;
  expLines.push_back({addr[31:5], 5'b00000});
  return 1'b0;
endfunction

// issues reqList back to back and waits for all responses
task automatic runReads();
  logic [31:0] a;
  expResp_t    e;
  accList.delete();
  while (reqList.size() > 0) begin
    a = reqList.pop_front();
    @(posedge clk);
    #1;
    coreReq.valid = 1'b1;
    coreReq.addr  = a;
    @(negedge clk);
    while (!coreResp.addrOk) @(negedge clk);
    e.addr     = a;
    e.accCycle = cycleCnt;
    e.hit      = predictAccess(a);
    expQ.push_back(e);
    accList.push_back(cycleCnt);
  end
  @(posedge clk);
  #1;
  coreReq.valid = 1'b0;
  while (expQ.size() > 0 || missBusy) @(negedge clk);
  assert (memReqCount == expMemReqs) else
    reportMismatch($sformatf("%0d memory requests, expected %0d", memReqCount, expMemReqs));
endtask

task automatic testReset();
  @(negedge clk);
  assert (!coreResp.addrOk && !coreResp.dataOk && !memReq.rdValid) else
    reportMismatch("handshake outputs not low after reset");
  reqList.push_back(makeAddr(7, 3, 1, 0));
  runReads();
  assert (memReqCount == 1) else reportMismatch("first read did not make one request");
endtask

task automatic testMissWord();
  // one cold line per word select, then every word of a present line
  for (int ws = 0; ws < 4; ws++) reqList.push_back(makeAddr(9, 20 + ws, ws, 4));
  for (int ws = 0; ws < 4; ws++) reqList.push_back(makeAddr(9, 20, ws, 0));
  runReads();
endtask

task automatic testHitStream();
  int cnt;
  reqList.push_back(makeAddr(5, 8, 0, 0));
  runReads();
  cnt = memReqCount;
  reqList.push_back(makeAddr(5, 8, 1, 0));
  runReads();
  for (int ws = 0; ws < 4; ws++) reqList.push_back(makeAddr(5, 8, ws, 0));
  runReads();
  for (int i = 1; i < 4; i++) begin
    assert (accList[i] == accList[0] + i) else
      reportMismatch("hits were not accepted on consecutive cycles");
  end
  assert (memReqCount == cnt) else reportMismatch("hit made a memory request");
endtask

task automatic testReplacement();
  int cnt;
  reqList.push_back(makeAddr(1, 40, 0, 0));
  reqList.push_back(makeAddr(2, 40, 1, 0));
  reqList.push_back(makeAddr(1, 40, 2, 0));
  reqList.push_back(makeAddr(3, 40, 3, 0));
  runReads();
  cnt = memReqCount;
  reqList.push_back(makeAddr(1, 40, 1, 0));
  runReads();
  assert (memReqCount == cnt) else reportMismatch("line A was evicted instead of B");
  reqList.push_back(makeAddr(2, 40, 0, 0));
  runReads();
  assert (memReqCount == cnt + 1) else reportMismatch("line B was still present");
endtask

task automatic testBackPressure();
  extraStall = 6;
  extraGap   = 2;
  reqList.push_back(makeAddr(11, 50, 1, 0));
  reqList.push_back(makeAddr(12, 51, 3, 2));
  reqList.push_back(makeAddr(11, 50, 2, 0));
  runReads();
  extraStall = 0;
  extraGap   = 0;
endtask

task automatic testRandomSweep();
  int tag;
  int idx;
  int ws;
  int off;
  for (int i = 0; i < 200; i++) begin
    tag = $unsigned($random(seed)) % 4;
    idx = 10 + $unsigned($random(seed)) % 3;
    ws  = $unsigned($random(seed)) % 4;
    off = $unsigned($random(seed)) % 8;
    reqList.push_back(makeAddr(tag, idx, ws, off));
  end
  runReads();
endtask

`endif

// File: tbCache.sv
`timescale 1ns/100ps
`default_nettype none

module tbCache;

  localparam int TimeoutCycles = 4000;

  typedef struct {
    logic [31:0] addr;
    logic        hit;
    int          accCycle;
  } expResp_t;

  logic                   clk;
  logic                   rst_n;
  cacheIfPkg::coreReq_t   coreReq;
  cacheIfPkg::coreResp_t  coreResp;
  cacheIfPkg::memReq_t    memReq;
  cacheIfPkg::memResp_t   memResp;

  int           seed;
  int           cycleCnt;
  int           memReqCount;
  int           beatCount;
  int           extraStall;
  int           extraGap;
  logic         missBusy;
  logic         missOpen = 1'b0;
  logic [31:0]  memLine;
  int           stall;
  int           gap;
  int           beatIdx;

  expResp_t     expQ[$];
  logic [31:0]  expLines[$];
  logic [31:0]  reqList[$];
  int           accList[$];

  icacheTop u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .coreReq_i  (coreReq),
    .coreResp_o (coreResp),
    .memReq_o   (memReq),
    .memResp_i  (memResp)
  );

  `include "tbTasks.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles) begin
      $display("TB FAILED");
      $fatal(1, "timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    end
  end

  // response checker, sampled mid-cycle
  always @(negedge clk) begin
    expResp_t e;
    if (rst_n) begin
      // a miss stays open from its memory request until its response
      if (memReq.rdValid) begin
        missOpen = 1'b1;
      end
      if (missOpen) begin
        assert (!coreResp.addrOk) else reportMismatch("addrOk high during a miss");
      end
      if (coreResp.dataOk) begin
        assert (expQ.size() > 0) else reportError("dataOk without an accepted request");
        e = expQ.pop_front();
        assert (coreResp.rdData == memWord(e.addr)) else
          reportMismatch($sformatf("addr %h read %h, expected %h", e.addr,
                                   coreResp.rdData, memWord(e.addr)));
        if (e.hit) begin
          assert (cycleCnt == e.accCycle + 1) else
            reportMismatch($sformatf("hit on %h took %0d cycles", e.addr,
                                     cycleCnt - e.accCycle));
        end else begin
          assert (beatCount == 4 * memReqCount) else
            reportError($sformatf("miss on %h answered before its four beats arrived",
                                  e.addr));
          missOpen = 1'b0;
        end
      end
    end
  end

  // burst memory with random stalls and beat gaps
  initial begin
    memResp     = '0;
    missBusy    = 1'b0;
    memReqCount = 0;
    beatCount   = 0;
    forever begin
      @(negedge clk);
      if (rst_n && memReq.rdValid) begin
        memLine  = memReq.addr;
        missBusy = 1'b1;
        assert (expLines.size() > 0 && memLine == expLines[0]) else
          reportMismatch($sformatf("unexpected memory request for line %h", memLine));
        void'(expLines.pop_front());
        stall = $unsigned($random(seed)) % 4 + extraStall;
        repeat (stall) begin
          @(negedge clk);
          assert (memReq.rdValid && memReq.addr == memLine) else
            reportMismatch("read request dropped or changed before acceptance");
        end
        @(posedge clk);
        #1;
        memResp.rdReady = 1'b1;
        @(negedge clk);
        assert (memReq.rdValid && memReq.addr == memLine) else
          reportMismatch("read request dropped at acceptance");
        @(posedge clk);
        #1;
        memResp.rdReady = 1'b0;
        memReqCount++;
        for (beatIdx = 0; beatIdx < 4; beatIdx++) begin
          gap = $unsigned($random(seed)) % 3 + extraGap;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          memResp.beatValid = 1'b1;
          memResp.beatLast  = (beatIdx == 3);
          memResp.beatData  = memWord(memLine + 32'(8 * beatIdx));
          @(posedge clk);
          #1;
          memResp.beatValid = 1'b0;
          memResp.beatLast  = 1'b0;
          beatCount++;
        end
        missBusy = 1'b0;
      end
    end
  end

  initial begin
    seed       = 32'hed3b2cf7;
    cycleCnt   = 0;
    extraStall = 0;
    extraGap   = 0;
    rst_n      = 1'b0;
    coreReq    = '0;
    resetModel();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    testReset();
    testMissWord();
    testHitStream();
    testReplacement();
    testBackPressure();
    testRandomSweep();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
